//--- design/mm_dma_settings.svh
`ifndef MM_DMA_SETTINGS_SVH
`define MM_DMA_SETTINGS_SVH

// register byte offsets, low address byte
`define MM_DMA_REG_CTRL     8'h00
`define MM_DMA_REG_BASE_A   8'h04
`define MM_DMA_REG_BASE_B   8'h08
`define MM_DMA_REG_RESULT0  8'h0C

`define MM_DMA_N            4
`define MM_DMA_ROW_STRIDE   16
`define MM_DMA_ELEM_STRIDE  4

`define MM_DMA_ADDR_UNSET   24'd3721  // base register not yet written

`endif

//--- design/wb_map_pkg.sv
`default_nettype none

package wb_map_pkg;

    typedef logic [7:0]  reg_off_t;  // low address byte
    typedef logic [31:0] wb_word_t;

    typedef struct packed {
        logic idle;
        logic done;
        logic start;
    } status_t;

endpackage

`default_nettype wire

//--- design/mm_core_pkg.sv
`default_nettype none

package mm_core_pkg;

    typedef logic signed [31:0] data_t;
    typedef logic [23:0]        sdram_addr_t;
    typedef logic [2:0]         group_t;    // a row 0, b col 0-3, a rows 1-3
    typedef logic [1:0]         elem_t;
    typedef logic [3:0]         res_idx_t;

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_req,
        fetch_wait,
        fetch_hold,
        fetch_done
    } fetch_state_t;

    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_armed,
        ctrl_detect,
        ctrl_stream_in,
        ctrl_stream_out,
        ctrl_done
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/wb_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "mm_dma_settings.svh"

module wb_csr (
    input  wire                            wb_clk_i,
    input  wire                            wb_rst_i,
    input  wire                            wbs_cyc_i,
    input  wire                            wbs_stb_i,
    input  wire                            wbs_we_i,
    input  wire wb_map_pkg::wb_word_t      wbs_adr_i,
    input  wire wb_map_pkg::wb_word_t      wbs_dat_i,
    output logic                           wbs_ack_o,
    output wb_map_pkg::wb_word_t           wbs_dat_o,
    output logic                           start_o,
    output mm_core_pkg::sdram_addr_t       base_a_o,
    output mm_core_pkg::sdram_addr_t       base_b_o,
    input  wire                            done_i,
    input  wire mm_core_pkg::data_t        result_i,
    output mm_core_pkg::res_idx_t          result_idx_o
);

    wb_map_pkg::reg_off_t off;
    wb_map_pkg::reg_off_t res_off;
    wb_map_pkg::status_t  status;
    wb_map_pkg::wb_word_t rdata;
    logic                 access;
    logic                 in_result;
    logic [1:0]           armed;    // bit 0 base a, bit 1 base b
    logic                 started;

    assign access       = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;  // never ack twice in a row
    assign off          = wbs_adr_i[7:0];
    assign res_off      = off - `MM_DMA_REG_RESULT0;
    assign in_result    = (off >= `MM_DMA_REG_RESULT0) && (res_off[1:0] == 2'b00)
                          && (res_off < 8'(`MM_DMA_N * `MM_DMA_N * `MM_DMA_ELEM_STRIDE));
    assign result_idx_o = res_off[5:2];
    assign status       = '{idle: !started, done: done_i, start: 1'b0};

    always_comb begin
        rdata = '0;
        if (off == `MM_DMA_REG_CTRL)
            rdata = {29'd0, status};
        else if (in_result && done_i)
            rdata = result_i;
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
            start_o   <= 1'b0;
            armed     <= 2'b00;
            started   <= 1'b0;
            base_a_o  <= `MM_DMA_ADDR_UNSET;
            base_b_o  <= `MM_DMA_ADDR_UNSET;
        end else begin
            wbs_ack_o <= access;
            start_o   <= 1'b0;
            if (access && wbs_we_i) begin
                case (off)
                    `MM_DMA_REG_BASE_A: begin
                        base_a_o <= wbs_dat_i[23:0];
                        armed[0] <= 1'b1;
                    end
                    `MM_DMA_REG_BASE_B: begin
                        base_b_o <= wbs_dat_i[23:0];
                        armed[1] <= 1'b1;
                    end
                    `MM_DMA_REG_CTRL: begin
                        if (wbs_dat_i == 32'd1 && armed == 2'b11 && !started) begin
                            start_o <= 1'b1;  // one run per reset
                            started <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            wbs_dat_o <= wbs_we_i ? '0 : rdata;
    end

endmodule

`default_nettype wire

//--- design/sdram_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "mm_dma_settings.svh"

module sdram_fetch (
    input  wire                            wb_clk_i,
    input  wire                            wb_rst_i,
    input  wire mm_core_pkg::sdram_addr_t  base_a_i,
    input  wire mm_core_pkg::sdram_addr_t  base_b_i,
    input  wire                            start_i,
    output mm_core_pkg::sdram_addr_t       mm_addr_o,
    output logic                           mm_in_valid_o,
    input  wire                            mm_busy_i,
    input  wire                            mm_out_valid_i,
    input  wire mm_core_pkg::data_t        mm_data_i,
    output logic                           stage_valid_o,
    output mm_core_pkg::data_t [3:0]       stage_data_o,
    input  wire                            stage_consumed_i
);

    mm_core_pkg::fetch_state_t state;
    mm_core_pkg::group_t       grp;
    mm_core_pkg::elem_t        elem;
    mm_core_pkg::sdram_addr_t  grp_start;
    mm_core_pkg::sdram_addr_t  step;
    logic                      a_row;
    logic                      word_in;

    assign a_row   = (grp == 3'd0) || (grp >= 3'd5);
    assign step    = a_row ? mm_core_pkg::sdram_addr_t'(`MM_DMA_ELEM_STRIDE)
                           : mm_core_pkg::sdram_addr_t'(`MM_DMA_ROW_STRIDE);
    assign word_in = (state == mm_core_pkg::fetch_wait) && mm_out_valid_i;

    // first address of groups 1 to 7
    always_comb begin
        if (grp >= 3'd5)
            grp_start = base_a_i
                + mm_core_pkg::sdram_addr_t'(`MM_DMA_ROW_STRIDE * (grp - 3'd4));
        else
            grp_start = base_b_i
                + mm_core_pkg::sdram_addr_t'(`MM_DMA_ELEM_STRIDE * (grp - 3'd1));
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state         <= mm_core_pkg::fetch_idle;
            mm_in_valid_o <= 1'b0;
            mm_addr_o     <= '0;
            grp           <= '0;
            elem          <= '0;
        end else begin
            case (state)
                mm_core_pkg::fetch_idle: begin
                    if (start_i && base_a_i != `MM_DMA_ADDR_UNSET) begin
                        mm_addr_o     <= base_a_i;
                        mm_in_valid_o <= 1'b1;
                        state         <= mm_core_pkg::fetch_req;
                    end
                end
                mm_core_pkg::fetch_req: begin
                    if (!mm_busy_i) begin  // request taken
                        mm_in_valid_o <= 1'b0;
                        state         <= mm_core_pkg::fetch_wait;
                    end
                end
                mm_core_pkg::fetch_wait: begin
                    if (mm_out_valid_i) begin
                        elem <= elem + 2'd1;
                        if (elem != 2'd3) begin
                            mm_addr_o     <= mm_addr_o + step;
                            mm_in_valid_o <= 1'b1;
                            state         <= mm_core_pkg::fetch_req;
                        end else if (grp == 3'd7) begin
                            state <= mm_core_pkg::fetch_done;
                        end else begin
                            grp   <= grp + 3'd1;
                            state <= mm_core_pkg::fetch_hold;
                        end
                    end
                end
                mm_core_pkg::fetch_hold: begin
                    if (!stage_valid_o) begin  // wait for engine to drain
                        mm_addr_o     <= grp_start;
                        mm_in_valid_o <= 1'b1;
                        state         <= mm_core_pkg::fetch_req;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i)
            stage_valid_o <= 1'b0;
        else if (word_in && elem == 2'd3)
            stage_valid_o <= 1'b1;
        else if (stage_consumed_i)
            stage_valid_o <= 1'b0;
    end

    always_ff @(posedge wb_clk_i) begin
        if (word_in)
            stage_data_o[elem] <= mm_data_i;
    end

endmodule

`default_nettype wire

//--- design/stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mm_dma_settings.svh"

module stream_ctrl (
    input  wire                            wb_clk_i,
    input  wire                            wb_rst_i,
    input  wire                            start_i,
    input  wire                            stage_valid_i,
    input  wire mm_core_pkg::data_t [3:0]  stage_data_i,
    output logic                           stage_consumed_o,
    output logic                           eng_start_o,
    output logic                           ss_tvalid_o,
    output mm_core_pkg::data_t             ss_tdata_o,
    input  wire                            ss_tready_i,
    input  wire                            sm_tvalid_i,
    input  wire mm_core_pkg::data_t        sm_tdata_i,
    output logic                           sm_tready_o,
    input  wire                            eng_done_i,
    output logic                           done_o,
    input  wire mm_core_pkg::res_idx_t     result_idx_i,
    output mm_core_pkg::data_t             result_o
);

    localparam int NRES = `MM_DMA_N * `MM_DMA_N;

    mm_core_pkg::ctrl_state_t state;
    mm_core_pkg::elem_t       cnt;
    mm_core_pkg::data_t       res_buf [NRES];
    logic                     ss_fire;

    assign ss_fire          = ss_tvalid_o && ss_tready_i;
    assign eng_start_o      = (state == mm_core_pkg::ctrl_armed);
    assign ss_tvalid_o      = (state == mm_core_pkg::ctrl_stream_in);
    assign ss_tdata_o       = stage_data_i[cnt];
    assign sm_tready_o      = (state == mm_core_pkg::ctrl_stream_out);
    assign stage_consumed_o = ss_fire && (cnt == 2'd3);
    assign done_o           = (state == mm_core_pkg::ctrl_done);
    assign result_o         = res_buf[result_idx_i];

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state <= mm_core_pkg::ctrl_idle;
            cnt   <= '0;
        end else begin
            case (state)
                mm_core_pkg::ctrl_idle: begin
                    if (start_i)
                        state <= mm_core_pkg::ctrl_armed;
                end
                mm_core_pkg::ctrl_armed: state <= mm_core_pkg::ctrl_detect;
                mm_core_pkg::ctrl_detect: begin
                    // results first, else engine could block on a full output
                    if (sm_tvalid_i)
                        state <= mm_core_pkg::ctrl_stream_out;
                    else if (eng_done_i)
                        state <= mm_core_pkg::ctrl_done;
                    else if (stage_valid_i && ss_tready_i)
                        state <= mm_core_pkg::ctrl_stream_in;
                end
                mm_core_pkg::ctrl_stream_in: begin
                    if (ss_fire) begin
                        cnt <= cnt + 2'd1;  // wraps after word 3
                        if (cnt == 2'd3)
                            state <= mm_core_pkg::ctrl_detect;
                    end
                end
                mm_core_pkg::ctrl_stream_out: state <= mm_core_pkg::ctrl_detect;
                default: ;
            endcase
        end
    end

    // shift down so c[0] lands at index 0
    always_ff @(posedge wb_clk_i) begin
        if (state == mm_core_pkg::ctrl_stream_out) begin
            for (int i = 0; i < NRES - 1; i++)
                res_buf[i] <= res_buf[i + 1];
            res_buf[NRES - 1] <= sm_tdata_i;
        end
    end

endmodule

`default_nettype wire

//--- design/mm_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "mm_dma_settings.svh"

module mm_engine (
    input  wire                       wb_clk_i,
    input  wire                       wb_rst_i,
    input  wire                       start_i,
    input  wire                       ss_tvalid_i,
    input  wire mm_core_pkg::data_t   ss_tdata_i,
    output logic                      ss_tready_o,
    output logic                      sm_tvalid_o,
    output mm_core_pkg::data_t        sm_tdata_o,
    input  wire                       sm_tready_i,
    output logic                      done_o
);

    mm_core_pkg::data_t    row [`MM_DMA_N];
    mm_core_pkg::data_t    bcol [`MM_DMA_N][`MM_DMA_N];
    mm_core_pkg::group_t   grp;
    mm_core_pkg::elem_t    word;
    mm_core_pkg::elem_t    col;
    mm_core_pkg::res_idx_t res_cnt;
    logic                  running;
    logic                  emitting;
    logic                  ss_fire;
    logic                  sm_fire;
    logic                  b_group;

    assign ss_tready_o = running && !emitting && !done_o;
    assign sm_tvalid_o = emitting;
    assign ss_fire     = ss_tvalid_i && ss_tready_o;
    assign sm_fire     = sm_tvalid_o && sm_tready_i;
    assign b_group     = (grp >= 3'd1) && (grp <= 3'd4);

    always_comb begin
        sm_tdata_o = '0;
        for (int k = 0; k < `MM_DMA_N; k++)
            sm_tdata_o = sm_tdata_o + row[k] * bcol[col][k];  // wraps at 32 bits
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            running  <= 1'b0;
            emitting <= 1'b0;
            done_o   <= 1'b0;
            grp      <= '0;
            word     <= '0;
            col      <= '0;
            res_cnt  <= '0;
        end else begin
            if (start_i)
                running <= 1'b1;
            if (ss_fire) begin
                word <= word + 2'd1;
                if (word == 2'd3) begin
                    grp      <= grp + 3'd1;
                    emitting <= (grp >= 3'd4);  // row held and all of b in
                end
            end
            if (sm_fire) begin
                col     <= col + 2'd1;
                res_cnt <= res_cnt + 4'd1;
                if (col == 2'd3)
                    emitting <= 1'b0;
                if (res_cnt == 4'd15)
                    done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (ss_fire) begin
            if (b_group)
                bcol[mm_core_pkg::elem_t'(grp - 3'd1)][word] <= ss_tdata_i;
            else
                row[word] <= ss_tdata_i;
        end
    end

endmodule

`default_nettype wire

//--- design/mm_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module mm_dma_top (
    input  wire                            wb_clk_i,
    input  wire                            wb_rst_i,
    input  wire                            wbs_cyc_i,
    input  wire                            wbs_stb_i,
    input  wire                            wbs_we_i,
    input  wire [3:0]                      wbs_sel_i,  // full words only
    input  wire wb_map_pkg::wb_word_t      wbs_adr_i,
    input  wire wb_map_pkg::wb_word_t      wbs_dat_i,
    output logic                           wbs_ack_o,
    output wb_map_pkg::wb_word_t           wbs_dat_o,
    output mm_core_pkg::sdram_addr_t       mm_addr_o,
    output logic                           mm_in_valid_o,
    input  wire                            mm_busy_i,
    input  wire                            mm_out_valid_i,
    input  wire mm_core_pkg::data_t        mm_data_i
);

    mm_core_pkg::sdram_addr_t  base_a;
    mm_core_pkg::sdram_addr_t  base_b;
    mm_core_pkg::data_t [3:0]  stage_data;
    mm_core_pkg::data_t        ss_tdata;
    mm_core_pkg::data_t        sm_tdata;
    mm_core_pkg::data_t        result;
    mm_core_pkg::res_idx_t     result_idx;
    logic                      start;
    logic                      done;
    logic                      stage_valid;
    logic                      stage_consumed;
    logic                      eng_start;
    logic                      eng_done;
    logic                      ss_tvalid;
    logic                      ss_tready;
    logic                      sm_tvalid;
    logic                      sm_tready;

    wb_csr i_csr (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .start_o      (start),
        .base_a_o     (base_a),
        .base_b_o     (base_b),
        .done_i       (done),
        .result_i     (result),
        .result_idx_o (result_idx)
    );

    sdram_fetch i_fetch (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .base_a_i         (base_a),
        .base_b_i         (base_b),
        .start_i          (start),
        .mm_addr_o        (mm_addr_o),
        .mm_in_valid_o    (mm_in_valid_o),
        .mm_busy_i        (mm_busy_i),
        .mm_out_valid_i   (mm_out_valid_i),
        .mm_data_i        (mm_data_i),
        .stage_valid_o    (stage_valid),
        .stage_data_o     (stage_data),
        .stage_consumed_i (stage_consumed)
    );

    stream_ctrl i_ctrl (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .start_i          (start),
        .stage_valid_i    (stage_valid),
        .stage_data_i     (stage_data),
        .stage_consumed_o (stage_consumed),
        .eng_start_o      (eng_start),
        .ss_tvalid_o      (ss_tvalid),
        .ss_tdata_o       (ss_tdata),
        .ss_tready_i      (ss_tready),
        .sm_tvalid_i      (sm_tvalid),
        .sm_tdata_i       (sm_tdata),
        .sm_tready_o      (sm_tready),
        .eng_done_i       (eng_done),
        .done_o           (done),
        .result_idx_i     (result_idx),
        .result_o         (result)
    );

    mm_engine i_engine (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .start_i     (eng_start),
        .ss_tvalid_i (ss_tvalid),
        .ss_tdata_i  (ss_tdata),
        .ss_tready_o (ss_tready),
        .sm_tvalid_o (sm_tvalid),
        .sm_tdata_o  (sm_tdata),
        .sm_tready_i (sm_tready),
        .done_o      (eng_done)
    );

endmodule

`default_nettype wire

//--- tb/mm_dma_props.sv
`timescale 1ns/1ps
`default_nettype none

module mm_dma_props (
    input wire        wb_clk_i,
    input wire        wb_rst_i,
    input wire        wbs_cyc_i,
    input wire        wbs_stb_i,
    input wire        wbs_ack_i,
    input wire        mm_in_valid_i,
    input wire        ss_tvalid_i,
    input wire        ss_tready_i,
    input wire [31:0] ss_tdata_i
);

    int unsigned fail_count = 0;  // read by the testbench summary

    ack_after_strobe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_i |-> $past(wbs_cyc_i && wbs_stb_i))
        else begin
            $error("ack without a strobe in the previous cycle");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_i |=> !wbs_ack_i)
        else begin
            $error("ack held high for two cycles");
            fail_count++;
        end

    ss_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ss_tvalid_i && !ss_tready_i |=> ss_tvalid_i && $stable(ss_tdata_i))
        else begin
            $error("engine input stream changed before it was taken");
            fail_count++;
        end

    // sync reset, so the output is only cleared after one edge
    req_low_in_reset: assert property (@(posedge wb_clk_i)
        wb_rst_i && $past(wb_rst_i) |-> !mm_in_valid_i)
        else begin
            $error("SDRAM request raised during reset");
            fail_count++;
        end

endmodule

bind mm_dma_top mm_dma_props i_props (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wbs_cyc_i     (wbs_cyc_i),
    .wbs_stb_i     (wbs_stb_i),
    .wbs_ack_i     (wbs_ack_o),
    .mm_in_valid_i (mm_in_valid_o),
    .ss_tvalid_i   (ss_tvalid),
    .ss_tready_i   (ss_tready),
    .ss_tdata_i    (ss_tdata)
);

`default_nettype wire

//--- tb/mm_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mm_dma_settings.svh"

module mm_dma_tb;

    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 1000;
    localparam int MEM_WORDS  = 256;  // model window 0x000 to 0x3ff

    logic        wb_clk_i;
    logic        wb_rst_i;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic [23:0] mm_addr_o;
    logic        mm_in_valid_o;
    logic        mm_busy_i;
    logic        mm_out_valid_i;
    logic [31:0] mm_data_i;

    logic [31:0] testdata [34];
    logic [31:0] sdram_mem [MEM_WORDS];
    logic [31:0] c_expected [16];
    logic [23:0] addr_log [$];
    logic [23:0] base_a;
    logic [23:0] base_b;
    logic [31:0] rng_state = 32'heb0d58c6;
    int          mismatches = 0;
    int          other_errors = 0;

    mm_dma_top i_dut (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_sel_i      (wbs_sel_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .mm_addr_o      (mm_addr_o),
        .mm_in_valid_o  (mm_in_valid_o),
        .mm_busy_i      (mm_busy_i),
        .mm_out_valid_i (mm_out_valid_i),
        .mm_data_i      (mm_data_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #10 wb_clk_i = ~wb_clk_i;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input logic [23:0] addr);
        return {8'hc3, addr ^ 24'h5a3c96};
    endfunction

    function automatic logic [31:0] model_read(input logic [23:0] addr);
        if (addr < 24'h400 && addr[1:0] == 2'b00)
            return sdram_mem[addr[9:2]];
        return fill_word(addr);
    endfunction

    // group 0 a row 0, groups 1-4 b columns, groups 5-7 a rows 1-3
    function automatic logic [23:0] expected_addr(input int n);
        int grp;
        int elem;
        grp  = n / 4;
        elem = n % 4;
        if (grp == 0)
            return base_a + 24'(`MM_DMA_ELEM_STRIDE * elem);
        if (grp <= 4)
            return base_b + 24'(`MM_DMA_ELEM_STRIDE * (grp - 1)) + 24'(`MM_DMA_ROW_STRIDE * elem);
        return base_a + 24'(`MM_DMA_ROW_STRIDE * (grp - 4)) + 24'(`MM_DMA_ELEM_STRIDE * elem);
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected)
        else begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        int prop_fails;
        prop_fails = int'(i_dut.i_props.fail_count);
        $display("summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, other_errors, prop_fails);
        if (mismatches + other_errors + prop_fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    // starts and ends on a falling edge
    task automatic wb_access(input logic we, input logic [7:0] off,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic acked;
        waited    = 0;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = {24'd0, off};
        wbs_dat_i = wdata;
        @(negedge wb_clk_i);
        while (!wbs_ack_o && waited < ACK_LIMIT) begin
            @(negedge wb_clk_i);
            waited++;
        end
        acked     = wbs_ack_o;
        rdata     = wbs_dat_o;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        if (!acked) begin
            other_errors++;
            $display("ERROR: no Wishbone ack for offset %h within %0d cycles", off, ACK_LIMIT);
        end
    endtask

    task automatic wb_write(input logic [7:0] off, input logic [31:0] data);
        logic [31:0] ignored;
        wb_access(1'b1, off, data, ignored);
    endtask

    task automatic wb_read(input logic [7:0] off, output logic [31:0] data);
        wb_access(1'b0, off, 32'd0, data);
    endtask

    // called on the falling edge before the taking rising edge
    task automatic serve_request();
        logic [23:0] addr;
        int          delay;
        addr = mm_addr_o;
        addr_log.push_back(addr);
        rng_state = next_random(rng_state);
        delay = 1 + int'(rng_state % 32'd6);
        @(negedge wb_clk_i);
        mm_busy_i = 1'b1;
        if (mm_in_valid_o !== 1'b0) begin
            other_errors++;
            $display("ERROR: SDRAM request at %h stayed valid after it was taken", addr);
        end
        repeat (delay - 1) @(negedge wb_clk_i);
        mm_data_i      = model_read(addr);
        mm_out_valid_i = 1'b1;
        @(negedge wb_clk_i);
        mm_out_valid_i = 1'b0;
        mm_busy_i      = 1'b0;
        mm_data_i      = 32'd0;
    endtask

    initial begin
        mm_busy_i      = 1'b0;
        mm_out_valid_i = 1'b0;
        mm_data_i      = 32'd0;
        forever begin
            @(negedge wb_clk_i);
            while (mm_in_valid_o === 1'b1 && !mm_busy_i)
                serve_request();
        end
    end

    task automatic load_model();
        logic [23:0] addr;
        for (int i = 0; i < MEM_WORDS; i++)
            sdram_mem[i] = fill_word(24'(4 * i));
        if (base_a > 24'h3c0 || base_b > 24'h3c0 || base_a[1:0] != 2'b00
                || base_b[1:0] != 2'b00) begin
            other_errors++;
            $display("ERROR: base addresses in the test data fall outside the SDRAM model");
        end else begin
            for (int i = 0; i < 16; i++) begin
                addr = base_a + 24'(4 * i);
                sdram_mem[addr[9:2]] = testdata[2 + i];
                addr = base_b + 24'(4 * i);
                sdram_mem[addr[9:2]] = testdata[18 + i];
            end
        end
    endtask

    task automatic compute_expected();
        logic [31:0] acc;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                acc = 32'd0;
                for (int k = 0; k < 4; k++)
                    acc = acc + testdata[2 + 4 * r + k] * testdata[18 + 4 * k + c];  // wraps
                c_expected[4 * r + c] = acc;
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] res_word;
        int          polls;
        wb_rst_i  = 1'b1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'hf;
        wbs_adr_i = 32'd0;
        wbs_dat_i = 32'd0;
        $readmemh("tb/mm_dma_testdata.hex", testdata);
        base_a = testdata[0][23:0];
        base_b = testdata[1][23:0];
        load_model();
        compute_expected();
        repeat (5) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;
        @(negedge wb_clk_i);

        wb_read(`MM_DMA_REG_CTRL, rd);
        check_word("status after reset", 32'd4, rd);
        wb_read(`MM_DMA_REG_RESULT0, rd);
        check_word("result[0] after reset", 32'd0, rd);
        wb_read(8'h48, rd);
        check_word("result[15] after reset", 32'd0, rd);

        // base b still unset, start must be dropped
        wb_write(`MM_DMA_REG_BASE_A, {8'd0, base_a});
        wb_write(`MM_DMA_REG_CTRL, 32'd1);
        repeat (20) @(negedge wb_clk_i);
        wb_read(`MM_DMA_REG_CTRL, rd);
        check_word("status after early start", 32'd4, rd);
        check_word("sdram requests after early start", 32'd0, 32'(addr_log.size()));

        wb_write(`MM_DMA_REG_BASE_B, {8'd0, base_b});
        wb_write(`MM_DMA_REG_CTRL, 32'd1);
        wb_read(`MM_DMA_REG_CTRL, rd);
        check_word("status while running", 32'd0, rd);
        polls = 0;
        while (rd != 32'd2 && polls < POLL_LIMIT) begin
            // result read first, a later running status proves it came before done
            wb_read(8'h48, res_word);
            wb_read(`MM_DMA_REG_CTRL, rd);
            if (rd == 32'd0)
                check_word("result[15] while running", 32'd0, res_word);
            polls++;
        end
        if (rd != 32'd2) begin
            other_errors++;
            $display("ERROR: status never reached done after %0d polls, last value %h",
                     polls, rd);
        end else begin
            check_word("sdram request count", 32'd32, 32'(addr_log.size()));
            for (int n = 0; n < 32 && n < addr_log.size(); n++)
                check_word($sformatf("sdram addr %0d", n), {8'd0, expected_addr(n)},
                           {8'd0, addr_log[n]});

            for (int i = 0; i < 16; i++) begin
                wb_read(8'(`MM_DMA_REG_RESULT0 + 4 * i), rd);
                check_word($sformatf("result[%0d]", i), c_expected[i], rd);
            end
            wb_read(8'h4c, rd);
            check_word("unmapped 0x4c", 32'd0, rd);
            wb_read(8'h80, rd);
            check_word("unmapped 0x80", 32'd0, rd);
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- tb/mm_dma_testdata.hex
// base A, base B, then A[0][0]..A[3][3] and B[0][0]..B[3][3], one hex word per line
// both matrices row-major, elements are signed 32-bit
00000100
00000200
00000001
00000002
00000003
00000004
fffffffb
00000006
fffffff9
00000008
7fffffff
00000010
00000000
80000000
0000abcd
12345678
ffff0000
00000003
00000002
00000000
00000001
ffffffff
00000003
00000001
00000000
00000002
10000000
00000004
fffffffe
00000005
00000007
00000100
00000009
7fffffff

//--- verilog.f
+incdir+design
design/wb_map_pkg.sv
design/mm_core_pkg.sv
design/wb_csr.sv
design/sdram_fetch.sv
design/stream_ctrl.sv
design/mm_engine.sv
design/mm_dma_top.sv
tb/mm_dma_props.sv
tb/mm_dma_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the matrix DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mm_dma_tb \
    -f verilog.f -o mm_dma_sim

out="$(./obj_dir/mm_dma_sim 2>&1)" || true
echo "$out"
grep -qx '=== PASS ===' <<< "$out"
